// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_decode_execute
FILELIST  := project.f
BUILD_DIR := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_decode_execute.sv
`timescale 1ns/1ps

module tb_decode_execute;

    localparam int clk_period    = 10;
    localparam int reset_cycles  = 3;              // two in reset plus one to check
    localparam int op_count      = 25;             // instructions issued over all tests
    localparam int cycles_per_op = 3;              // drive, id/ex capture, ex/mem capture
    localparam int timeout_ns    = (reset_cycles + op_count * cycles_per_op) * clk_period + 200;
    localparam logic [31:0] lfsr_taps = 32'hA300_0000;

    logic clk, rst_n, id_no_op;
    logic [31:0] instruction, pc, reg_1_value, reg_2_value;
    logic [1:0] hazard_control;
    logic [4:0] ex_reg_1_idx, ex_reg_2_idx, ex_dest_idx;
    pipe_pkg::redirect_t   redirect;
    pipe_pkg::mem_bundle_t mem;
    logic [31:0] lfsr_state;                       // galois lfsr for operands and fields

    decode_execute dut0 (
        .clk(clk), .rst_n(rst_n), .instruction(instruction), .pc(pc),
        .reg_1_value(reg_1_value), .reg_2_value(reg_2_value), .hazard_control(hazard_control),
        .id_no_op(id_no_op), .redirect(redirect), .ex_reg_1_idx(ex_reg_1_idx),
        .ex_reg_2_idx(ex_reg_2_idx), .ex_dest_idx(ex_dest_idx), .mem(mem)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin                                  // watchdog
        #(timeout_ns);
        $display("watchdog expired before all tests finished");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] rand_bits(input int n);  // one lfsr step per bit
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lsb        = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lsb ? lfsr_taps : 32'h0);
            v          = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic logic [31:0] sign_ext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] encode_r(input isa_pkg::funct_e fn, input logic [4:0] rs,
                                             input logic [4:0] rt, rd, sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input isa_pkg::opcode_e op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic compare(input string test, input string field,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected 0x%08h actual 0x%08h", test, field, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch in %s", test);
        end
    endtask

    // drive one slot and return after id/ex has captured it
    task automatic issue(input logic [31:0] instr, input logic [31:0] pc_v, a, b,
                         input logic [1:0] hz, input logic kill);
        @(posedge clk);
        instruction    <= instr;
        pc             <= pc_v;
        reg_1_value    <= a;
        reg_2_value    <= b;
        hazard_control <= hz;
        id_no_op       <= kill;
        @(posedge clk);
        @(negedge clk);                            // sample away from the edge
    endtask

    task automatic advance();                      // one more edge so ex/mem holds the slot
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic reset_state();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare("reset_state", "pc_offset", 32'h0, 32'(redirect.pc_offset));
        compare("reset_state", "pc_overload", 32'h0, 32'(redirect.pc_overload));
        compare("reset_state", "reg_write", 32'h0, 32'(mem.reg_write));
        compare("reset_state", "mem_control", 32'h0, 32'(mem.mem_control));
    endtask

    task automatic r_type_alu(input isa_pkg::funct_e fn);
        logic [31:0] a, b, expected;
        logic [4:0]  rs, rt, rd, sh;
        a  = rand_bits(32);
        b  = rand_bits(32);
        rs = 5'(rand_bits(5));
        rt = 5'(rand_bits(5));
        rd = 5'(rand_bits(5));
        sh = 5'(rand_bits(5));
        case (fn)
            isa_pkg::fn_add: expected = a + b;
            isa_pkg::fn_sub: expected = a - b;
            isa_pkg::fn_and: expected = a & b;
            isa_pkg::fn_or:  expected = a | b;
            isa_pkg::fn_slt: expected = 32'($signed(a) < $signed(b));
            isa_pkg::fn_sll: expected = b << sh;   // rt is the shifted source
            default:         expected = b >> sh;   // srl
        endcase
        issue(encode_r(fn, rs, rt, rd, sh), 32'h0040_0000, a, b, 2'b00, 1'b0);
        compare("r_type_alu", "ex_reg_1_idx", 32'(rs), 32'(ex_reg_1_idx));
        compare("r_type_alu", "ex_reg_2_idx", 32'(rt), 32'(ex_reg_2_idx));
        advance();
        compare("r_type_alu", "alu_result", expected, mem.alu_result);
        compare("r_type_alu", "dest_idx", 32'(rd), 32'(mem.dest_idx));
        compare("r_type_alu", "reg_write", 32'h1, 32'(mem.reg_write));
    endtask

    task automatic i_type_mem(input isa_pkg::opcode_e op);
        logic [31:0] a, b, ext, expected;
        logic [15:0] imm;
        logic [4:0]  rs, rt, dest;
        logic [1:0]  mem_ctrl;
        a        = rand_bits(32);
        b        = rand_bits(32);
        imm      = 16'(rand_bits(16));
        rs       = 5'(rand_bits(5));
        rt       = 5'(rand_bits(5));
        ext      = sign_ext(imm);
        dest     = rt;
        mem_ctrl = 2'b00;
        case (op)
            isa_pkg::op_andi: begin
                ext      = {16'h0, imm};           // logical ops zero-extend
                expected = a & ext;
            end
            isa_pkg::op_ori: begin
                ext      = {16'h0, imm};
                expected = a | ext;
            end
            isa_pkg::op_slti: expected = 32'($signed(a) < $signed(ext));
            isa_pkg::op_lui: begin
                ext      = {imm, 16'h0};
                expected = ext;
            end
            isa_pkg::op_lw: begin
                expected = a + ext;
                mem_ctrl = 2'b10;
            end
            isa_pkg::op_sw: begin
                expected = a + ext;
                mem_ctrl = 2'b01;
                dest     = 5'd0;                   // store writes no register
            end
            default: expected = a + ext;           // addi
        endcase
        issue(encode_i(op, rs, rt, imm), 32'h0040_0100, a, b, 2'b00, 1'b0);
        compare("i_type_mem", "immediate", ext, redirect.offset_value);
        advance();
        compare("i_type_mem", "alu_result", expected, mem.alu_result);
        compare("i_type_mem", "mem_control", 32'(mem_ctrl), 32'(mem.mem_control));
        compare("i_type_mem", "reg_write", 32'(op != isa_pkg::op_sw), 32'(mem.reg_write));
        compare("i_type_mem", "dest_idx", 32'(dest), 32'(mem.dest_idx));
        compare("i_type_mem", "store_data", b, mem.store_data);
    endtask

    task automatic branch_redirect(input isa_pkg::opcode_e op, input logic equal);
        logic [31:0] a, b;
        logic [15:0] imm;
        logic        taken;
        a     = rand_bits(32);
        b     = equal ? a : a ^ (rand_bits(32) | 32'h1);  // nonzero xor keeps them apart
        imm   = 16'(rand_bits(16));
        taken = (op == isa_pkg::op_beq) ? equal : !equal;
        issue(encode_i(op, 5'd2, 5'd3, imm), 32'h0040_0200, a, b, 2'b00, 1'b0);
        compare("branch_redirect", "pc_offset", 32'(taken), 32'(redirect.pc_offset));
        compare("branch_redirect", "offset_value", sign_ext(imm), redirect.offset_value);
        compare("branch_redirect", "ex_dest_idx", 32'h0, 32'(ex_dest_idx));
        advance();
        compare("branch_redirect", "reg_write", 32'h0, 32'(mem.reg_write));
    endtask

    task automatic jump_redirect(input isa_pkg::opcode_e op);
        logic [31:0] pc_v, pc_4, a;
        logic [25:0] target;
        logic        link;
        pc_v   = rand_bits(30) << 2;
        pc_4   = pc_v + 32'd4;
        target = 26'(rand_bits(26));
        a      = rand_bits(32);
        link   = (op == isa_pkg::op_jal);
        if (op == isa_pkg::op_r_type)              // jr through rs
            issue(encode_r(isa_pkg::fn_jr, 5'd9, 5'd0, 5'd0, 5'd0), pc_v, a, 32'h0, 2'b00, 1'b0);
        else
            issue({op, target}, pc_v, a, 32'h0, 2'b00, 1'b0);
        compare("jump_redirect", "pc_overload", 32'h1, 32'(redirect.pc_overload));
        compare("jump_redirect", "overload_value",
                (op == isa_pkg::op_r_type) ? a : {pc_4[31:28], target, 2'b00},
                redirect.overload_value);
        advance();
        compare("jump_redirect", "reg_write", 32'(link), 32'(mem.reg_write));
        if (link) begin
            compare("jump_redirect", "link_value", pc_4, mem.alu_result);
            compare("jump_redirect", "link_dest", 32'd31, 32'(mem.dest_idx));
        end
    endtask

    task automatic hazard_hold_no_op();
        logic [31:0] a, b, kept;
        logic [25:0] target;
        logic [15:0] imm;
        a      = rand_bits(32);
        b      = rand_bits(32);
        imm    = 16'(rand_bits(16));
        target = 26'(rand_bits(26));
        kept   = {4'h1, target, 2'b00};            // pc+4 region of 0x1000_0040
        issue({isa_pkg::op_j, target}, 32'h1000_0040, a, b, 2'b00, 1'b0);
        compare("hazard_hold_no_op", "overload_value", kept, redirect.overload_value);
        issue(encode_i(isa_pkg::op_beq, 5'd7, 5'd9, imm), 32'h1000_0044, a, a, 2'b01, 1'b0);
        compare("hazard_hold_no_op", "held_pc_offset", 32'h0, 32'(redirect.pc_offset));
        compare("hazard_hold_no_op", "held_overload", kept, redirect.overload_value);
        compare("hazard_hold_no_op", "held_reg_2_idx", 32'h0, 32'(ex_reg_2_idx));
        issue(encode_i(isa_pkg::op_addi, 5'd3, 5'd4, imm), 32'h1000_0048, a, b, 2'b10, 1'b0);
        advance();
        compare("hazard_hold_no_op", "no_op_reg_write", 32'h0, 32'(mem.reg_write));
        compare("hazard_hold_no_op", "no_op_result", a + sign_ext(imm), mem.alu_result);
        issue(encode_i(isa_pkg::op_lw, 5'd5, 5'd6, imm), 32'h1000_004c, a, b, 2'b00, 1'b1);
        advance();
        compare("hazard_hold_no_op", "id_no_op_mem_ctrl", 32'h0, 32'(mem.mem_control));
        compare("hazard_hold_no_op", "id_no_op_reg_write", 32'h0, 32'(mem.reg_write));
    endtask

    initial begin
        lfsr_state = 32'd81164;
        rst_n          <= 1'b0;
        instruction    <= '0;
        pc             <= '0;
        reg_1_value    <= '0;
        reg_2_value    <= '0;
        hazard_control <= 2'b00;
        id_no_op       <= 1'b0;
        reset_state();
        r_type_alu(isa_pkg::fn_add);
        r_type_alu(isa_pkg::fn_sub);
        r_type_alu(isa_pkg::fn_and);
        r_type_alu(isa_pkg::fn_or);
        r_type_alu(isa_pkg::fn_slt);
        r_type_alu(isa_pkg::fn_sll);
        r_type_alu(isa_pkg::fn_srl);
        i_type_mem(isa_pkg::op_addi);
        i_type_mem(isa_pkg::op_andi);
        i_type_mem(isa_pkg::op_ori);
        i_type_mem(isa_pkg::op_slti);
        i_type_mem(isa_pkg::op_lui);
        i_type_mem(isa_pkg::op_lw);
        i_type_mem(isa_pkg::op_sw);
        branch_redirect(isa_pkg::op_beq, 1'b1);
        branch_redirect(isa_pkg::op_beq, 1'b0);
        branch_redirect(isa_pkg::op_bne, 1'b1);
        branch_redirect(isa_pkg::op_bne, 1'b0);
        jump_redirect(isa_pkg::op_j);
        jump_redirect(isa_pkg::op_jal);
        jump_redirect(isa_pkg::op_r_type);
        hazard_hold_no_op();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: hdl/decode_execute.sv
`timescale 1ns/1ps

module decode_execute (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [isa_pkg::isa_width-1:0]     instruction,
    input  logic [isa_pkg::isa_width-1:0]     pc,
    input  logic [isa_pkg::isa_width-1:0]     reg_1_value,
    input  logic [isa_pkg::isa_width-1:0]     reg_2_value,
    input  logic [1:0]                        hazard_control,
    input  logic                              id_no_op,
    output pipe_pkg::redirect_t                redirect,      // to fetch
    output logic [isa_pkg::reg_idx_width-1:0] ex_reg_1_idx,  // to forwarding unit
    output logic [isa_pkg::reg_idx_width-1:0] ex_reg_2_idx,
    output logic [isa_pkg::reg_idx_width-1:0] ex_dest_idx,   // forwarding and hazard units
    output pipe_pkg::mem_bundle_t              mem
);

    pipe_pkg::id_ctrl_t            id_ctrl;
    logic [isa_pkg::isa_width-1:0] immediate;
    pipe_pkg::ex_bundle_t          ex;

    decode_unit decode_unit0 (
        .instruction(instruction), .reg_1_value(reg_1_value), .reg_2_value(reg_2_value),
        .id_ctrl(id_ctrl), .immediate(immediate)
    );

    id_ex_reg id_ex_reg0 (
        .clk(clk), .rst_n(rst_n), .hazard_control(hazard_control), .id_no_op(id_no_op),
        .instruction(instruction), .pc(pc), .reg_1_value(reg_1_value),
        .reg_2_value(reg_2_value), .id_ctrl(id_ctrl), .immediate(immediate),
        .ex(ex), .redirect(redirect)
    );

    execute_unit execute_unit0 (
        .clk(clk), .rst_n(rst_n), .ex(ex), .mem(mem)
    );

    assign ex_reg_1_idx = ex.reg_1_idx;
    assign ex_reg_2_idx = ex.reg_2_idx;
    assign ex_dest_idx  = ex.dest_idx;

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic [isa_pkg::isa_width-1:0] instruction,
    input  logic [isa_pkg::isa_width-1:0] reg_1_value,  // rs value from the register file
    input  logic [isa_pkg::isa_width-1:0] reg_2_value,  // rt value
    output pipe_pkg::id_ctrl_t             id_ctrl,
    output logic [isa_pkg::isa_width-1:0] immediate
);

    isa_pkg::opcode_e                opcode;
    isa_pkg::funct_e                 funct;
    logic [isa_pkg::imm_width-1:0]   imm16;
    logic                            regs_equal;

    assign opcode     = isa_pkg::opcode_e'(instruction[31:26]);
    assign funct      = isa_pkg::funct_e'(instruction[5:0]);
    assign imm16      = instruction[isa_pkg::imm_width-1:0];
    assign regs_equal = (reg_1_value == reg_2_value);

    always_comb begin
        id_ctrl        = '0;                           // unknown opcodes decode as a bubble
        id_ctrl.alu_op = isa_pkg::alu_pass;
        unique case (opcode)
            isa_pkg::op_r_type: begin
                id_ctrl.r_type    = 1'b1;
                id_ctrl.reg_write = 1'b1;
                unique case (funct)
                    isa_pkg::fn_add: id_ctrl.alu_op = isa_pkg::alu_add;
                    isa_pkg::fn_sub: id_ctrl.alu_op = isa_pkg::alu_sub;
                    isa_pkg::fn_and: id_ctrl.alu_op = isa_pkg::alu_and;
                    isa_pkg::fn_or:  id_ctrl.alu_op = isa_pkg::alu_or;
                    isa_pkg::fn_slt: id_ctrl.alu_op = isa_pkg::alu_slt;
                    isa_pkg::fn_sll: id_ctrl.alu_op = isa_pkg::alu_sll;
                    isa_pkg::fn_srl: id_ctrl.alu_op = isa_pkg::alu_srl;
                    isa_pkg::fn_jr: begin
                        id_ctrl.r_type    = 1'b0;      // jr is its own class
                        id_ctrl.jr        = 1'b1;
                        id_ctrl.reg_write = 1'b0;
                    end
                    default: begin
                        id_ctrl.r_type    = 1'b0;
                        id_ctrl.reg_write = 1'b0;
                    end
                endcase
            end
            isa_pkg::op_j:   id_ctrl.j = 1'b1;
            isa_pkg::op_jal: begin
                id_ctrl.jal       = 1'b1;
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_op    = isa_pkg::alu_add;  // pc + 4 into the link register
            end
            isa_pkg::op_beq, isa_pkg::op_bne: id_ctrl.branch = 1'b1;
            isa_pkg::op_addi, isa_pkg::op_slti, isa_pkg::op_andi,
            isa_pkg::op_ori, isa_pkg::op_lui, isa_pkg::op_lw: begin
                id_ctrl.i_type    = 1'b1;
                id_ctrl.reg_write = 1'b1;
                case (opcode)                          // operation within the i-type group
                    isa_pkg::op_slti: id_ctrl.alu_op = isa_pkg::alu_slt;
                    isa_pkg::op_andi: id_ctrl.alu_op = isa_pkg::alu_and;
                    isa_pkg::op_ori:  id_ctrl.alu_op = isa_pkg::alu_or;
                    isa_pkg::op_lui:  id_ctrl.alu_op = isa_pkg::alu_lui;
                    default:          id_ctrl.alu_op = isa_pkg::alu_add; // addi, lw address
                endcase
                if (opcode == isa_pkg::op_lw)
                    id_ctrl.mem_control = 2'b10;       // read
            end
            isa_pkg::op_sw: begin
                id_ctrl.store       = 1'b1;
                id_ctrl.mem_control = 2'b01;           // write
                id_ctrl.alu_op      = isa_pkg::alu_add;
            end
            default: ;
        endcase
        id_ctrl.condition_satisfied = (opcode == isa_pkg::op_beq) ?  regs_equal :
                                      (opcode == isa_pkg::op_bne) ? !regs_equal : 1'b0;
    end

    always_comb begin
        case (opcode)
            isa_pkg::op_andi, isa_pkg::op_ori:             // logical ops zero-extend
                immediate = {{(isa_pkg::isa_width-isa_pkg::imm_width){1'b0}}, imm16};
            isa_pkg::op_lui:
                immediate = {imm16, {isa_pkg::imm_width{1'b0}}};
            default:
                immediate = {{(isa_pkg::isa_width-isa_pkg::imm_width){imm16[15]}}, imm16};
        endcase
    end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe_pkg::ex_bundle_t ex,
    output pipe_pkg::mem_bundle_t mem
);

    logic [isa_pkg::isa_width-1:0] alu_result;
    logic                          less_than;      // signed compare for slt / slti

    assign less_than = $signed(ex.operand_1) < $signed(ex.operand_2);

    always_comb begin
        unique case (ex.alu_op)
            isa_pkg::alu_add:  alu_result = ex.operand_1 + ex.operand_2;
            isa_pkg::alu_sub:  alu_result = ex.operand_1 - ex.operand_2;
            isa_pkg::alu_and:  alu_result = ex.operand_1 & ex.operand_2;
            isa_pkg::alu_or:   alu_result = ex.operand_1 | ex.operand_2;
            isa_pkg::alu_slt:  alu_result = {{(isa_pkg::isa_width-1){1'b0}}, less_than};
            isa_pkg::alu_sll:  alu_result = ex.operand_2 << ex.shamt;  // rt shifted
            isa_pkg::alu_srl:  alu_result = ex.operand_2 >> ex.shamt;  // logical, zero fill
            isa_pkg::alu_lui:  alu_result = ex.operand_2;   // decode did the shift
            isa_pkg::alu_pass: alu_result = ex.operand_1;
            default:           alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem <= '0;
        end else begin
            mem.reg_write   <= ex.reg_write & ~ex.no_op;          // bubble never commits
            mem.mem_control <= ex.no_op ? 2'b00 : ex.mem_control;
            mem.alu_result  <= alu_result;                         // data moves regardless
            mem.store_data  <= ex.store_data;
            mem.dest_idx    <= ex.dest_idx;
        end
    end

    // a load and a store from one decoded instruction would be a decode fault
    assert property (@(posedge clk) disable iff (!rst_n) mem.mem_control != 2'b11)
        else $error("execute_unit: memory read and write requested together");

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [1:0]                    hazard_control, // from the hazard unit
    input  logic                          id_no_op,       // id stage already killed this slot
    input  logic [isa_pkg::isa_width-1:0] instruction,
    input  logic [isa_pkg::isa_width-1:0] pc,
    input  logic [isa_pkg::isa_width-1:0] reg_1_value,
    input  logic [isa_pkg::isa_width-1:0] reg_2_value,
    input  pipe_pkg::id_ctrl_t             id_ctrl,
    input  logic [isa_pkg::isa_width-1:0] immediate,
    output pipe_pkg::ex_bundle_t           ex,
    output pipe_pkg::redirect_t            redirect
);

    logic [isa_pkg::reg_idx_width-1:0] rs, rt, rd;
    logic [isa_pkg::isa_width-1:0]     pc_4;
    logic                              j_normal;       // j or jal, both use the 26-bit target
    logic                              i_abnormal;     // store or branch, no rt write
    pipe_pkg::ex_bundle_t              ex_next;
    pipe_pkg::redirect_t               redirect_next;

    assign rs         = instruction[25:21];
    assign rt         = instruction[20:16];
    assign rd         = instruction[15:11];
    assign pc_4       = pc + 32'd4;
    assign j_normal   = id_ctrl.j | id_ctrl.jal;
    assign i_abnormal = id_ctrl.store | id_ctrl.branch;

    always_comb begin
        redirect_next.pc_offset      = id_ctrl.branch & id_ctrl.condition_satisfied;
        redirect_next.pc_overload    = j_normal | id_ctrl.jr;
        redirect_next.overload_value = j_normal ?
            {pc_4[isa_pkg::isa_width-1:isa_pkg::jump_addr_width+2],  // keep the pc+4 region
             instruction[isa_pkg::jump_addr_width-1:0], 2'b00} :
            reg_1_value;                                // jr target
        redirect_next.offset_value   = immediate;

        ex_next.no_op       = hazard_control[pipe_pkg::hazd_no_op_bit] | id_no_op;
        ex_next.reg_write   = id_ctrl.reg_write;
        ex_next.mem_control = id_ctrl.mem_control;
        ex_next.alu_op      = id_ctrl.alu_op;
        ex_next.shamt       = instruction[10:6];
        ex_next.operand_1   = id_ctrl.jal ? pc : reg_1_value;   // jal computes pc + 4
        if (id_ctrl.i_type | id_ctrl.store)
            ex_next.operand_2 = immediate;              // sw address is base + offset
        else if (id_ctrl.jal)
            ex_next.operand_2 = 32'd4;
        else
            ex_next.operand_2 = reg_2_value;
        ex_next.store_data  = reg_2_value;
        ex_next.reg_1_idx   = j_normal ? '0 : rs;      // jumps read no register
        ex_next.reg_2_idx   = (id_ctrl.r_type | i_abnormal) ? rt : '0;
        if (id_ctrl.jal)
            ex_next.dest_idx = isa_pkg::link_reg;
        else if (id_ctrl.jr)
            ex_next.dest_idx = rs;                      // reg_write is 0, index kept for hazards
        else if (i_abnormal)
            ex_next.dest_idx = '0;
        else if (id_ctrl.i_type)
            ex_next.dest_idx = rt;
        else if (id_ctrl.r_type)
            ex_next.dest_idx = rd;
        else
            ex_next.dest_idx = '0;                      // j and unknown opcodes
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex       <= '0;
            redirect <= '0;
        end else if (hazard_control[pipe_pkg::hazd_hold_bit]) begin
            ex.no_op <= ex_next.no_op;                  // bubble request still gets through
        end else begin
            ex       <= ex_next;
            redirect <= redirect_next;
        end
    end

    // fetch can follow only one redirect per cycle
    assert property (@(posedge clk) disable iff (!rst_n)
                     !(redirect.pc_offset && redirect.pc_overload))
        else $error("id_ex_reg: branch and jump redirect both set");

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

    localparam int isa_width       = 32;       // data path and pc width
    localparam int reg_idx_width   = 5;        // register file index
    localparam int alu_ctrl_width  = 4;        // alu operation code
    localparam int jump_addr_width = 26;       // j / jal target field
    localparam int opcode_width    = 6;        // instruction[31:26]
    localparam int funct_width     = 6;        // instruction[5:0]
    localparam int imm_width       = 16;       // instruction[15:0]
    localparam int shamt_width     = 5;        // instruction[10:6]

    localparam logic [reg_idx_width-1:0] link_reg = 5'd31; // jal return address goes here

    typedef enum logic [opcode_width-1:0] {
        op_r_type = 6'h00,                     // funct picks the operation
        op_j      = 6'h02,
        op_jal    = 6'h03,
        op_beq    = 6'h04,
        op_bne    = 6'h05,
        op_addi   = 6'h08,
        op_slti   = 6'h0a,
        op_andi   = 6'h0c,
        op_ori    = 6'h0d,
        op_lui    = 6'h0f,
        op_lw     = 6'h23,
        op_sw     = 6'h2b
    } opcode_e;

    typedef enum logic [funct_width-1:0] {
        fn_sll = 6'h00,                        // shift by shamt, not by rs
        fn_srl = 6'h02,
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [alu_ctrl_width-1:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_slt,
        alu_sll, alu_srl,
        alu_lui,                               // operand_2 comes in already shifted up
        alu_pass                               // forwards operand_1 untouched
    } alu_op_e;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

    localparam int hazd_hold_bit  = 0;         // keep the id/ex contents
    localparam int hazd_no_op_bit = 1;         // bubble into ex

    typedef struct packed {
        logic                  i_type;         // alu / load with immediate operand
        logic                  r_type;         // register-register, jr excluded
        logic                  j;
        logic                  jr;
        logic                  jal;
        logic                  branch;         // beq or bne
        logic                  store;
        logic                  reg_write;
        logic [1:0]            mem_control;    // [0] write, [1] read
        isa_pkg::alu_op_e      alu_op;
        logic                  condition_satisfied; // branch compare result
    } id_ctrl_t;

    typedef struct packed {
        logic                                  no_op;       // squash side effects in ex
        logic                                  reg_write;
        logic [1:0]                            mem_control;
        isa_pkg::alu_op_e                      alu_op;
        logic [isa_pkg::shamt_width-1:0]       shamt;
        logic [isa_pkg::isa_width-1:0]         operand_1;
        logic [isa_pkg::isa_width-1:0]         operand_2;
        logic [isa_pkg::isa_width-1:0]         store_data;  // rt value for sw
        logic [isa_pkg::reg_idx_width-1:0]     reg_1_idx;   // for forwarding
        logic [isa_pkg::reg_idx_width-1:0]     reg_2_idx;
        logic [isa_pkg::reg_idx_width-1:0]     dest_idx;
    } ex_bundle_t;

    typedef struct packed {
        logic                                  pc_offset;      // taken branch
        logic                                  pc_overload;    // j, jal, jr
        logic [isa_pkg::isa_width-1:0]         overload_value; // absolute target
        logic [isa_pkg::isa_width-1:0]         offset_value;   // branch displacement
    } redirect_t;

    typedef struct packed {
        logic                                  reg_write;
        logic [1:0]                            mem_control;
        logic [isa_pkg::isa_width-1:0]         alu_result;     // also the memory address
        logic [isa_pkg::isa_width-1:0]         store_data;
        logic [isa_pkg::reg_idx_width-1:0]     dest_idx;
    } mem_bundle_t;

endpackage

// File: project.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/decode_unit.sv
hdl/id_ex_reg.sv
hdl/execute_unit.sv
hdl/decode_execute.sv
dv/tb_decode_execute.sv
